//--- design/l1_pkg.sv
package l1_pkg;

  // number of initiator ports sharing the scratchpad.
  localparam int unsigned N_PORTS = 4;

  // number of word-interleaved banks.
  localparam int unsigned N_BANK = 8;

  // depth of each bank in words.
  localparam int unsigned N_WORDS = 256;

  // data path width and the matching number of byte enables.
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W = DATA_W / 8;

  // byte address width as seen by the initiators.
  localparam int unsigned ADDR_W = 32;

  // the request id carries the index of the issuing port.
  localparam int unsigned ID_W = $clog2(N_PORTS);

  // consecutive words land in consecutive banks, so the bank field
  // sits right above the byte offset inside a word.
  localparam int unsigned BANK_SEL_LSB = 2;
  localparam int unsigned BANK_SEL_W = $clog2(N_BANK);

  // the word index inside a bank follows the bank field.
  // address bits above this field are ignored, so addresses alias.
  localparam int unsigned ROW_LSB = BANK_SEL_LSB + BANK_SEL_W;
  localparam int unsigned ROW_W = $clog2(N_WORDS);

  // one request as driven by a port and as forwarded to a bank.
  // wen is active low, so a read has wen set.
  typedef struct packed {
    logic              req;
    logic              wen;
    logic [ADDR_W-1:0] add;
    logic [DATA_W-1:0] data;
    logic [BE_W-1:0]   be;
    logic [ID_W-1:0]   id;
  } mem_req_t;

  // one bank response, tagged with the id of the request it answers.
  typedef struct packed {
    logic              r_valid;
    logic [DATA_W-1:0] r_data;
    logic [ID_W-1:0]   r_id;
  } mem_rsp_t;

  // response as seen at a port, after the id has been used for routing.
  typedef struct packed {
    logic              r_valid;
    logic [DATA_W-1:0] r_data;
  } port_rsp_t;

endpackage

//--- design/tc_sram.sv
`timescale 1ns/1ps

module tc_sram #(
  parameter int unsigned NumWords  = 256,
  parameter int unsigned DataWidth = 32
) (
  input  logic                        clk_i,
  input  logic                        rstn_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [$clog2(NumWords)-1:0] addr_i,
  input  logic [DataWidth-1:0]        wdata_i,
  input  logic [DataWidth/8-1:0]      be_i,
  output logic [DataWidth-1:0]        rdata_o
);

  // storage array, one entry per word.
  logic [DataWidth-1:0] mem_q [NumWords];

  // simulation starts from an all-zero memory, so reads of words that
  // were never written return zero.
  initial begin
    for (int unsigned w = 0; w < NumWords; w++) begin
      mem_q[w] = '0;
    end
  end

  // write port.
  // only the byte lanes whose enable is set are updated.
  always @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int unsigned b = 0; b < DataWidth / 8; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // read port with one cycle of latency.
  // the read samples the array before a write at the same edge lands,
  // so a read returns the old contents.
  // on a write the output keeps its previous value.
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

//--- design/l1_mem_wrap.sv
`timescale 1ns/1ps

module l1_mem_wrap (
  input  logic                                  clk_i,
  input  logic                                  rstn_i,
  input  l1_pkg::mem_req_t [l1_pkg::N_BANK-1:0] bank_req_i,
  output l1_pkg::mem_rsp_t [l1_pkg::N_BANK-1:0] bank_rsp_o
);

  // every bank accepts a request in every cycle.
  // the grant toward the crossbar is therefore constant high and is not
  // carried on any wire, the crossbar arbitration alone decides acceptance.
  for (genvar i = 0; i < l1_pkg::N_BANK; i++) begin : gen_bank
    logic [l1_pkg::DATA_W-1:0] rdata;
    logic [l1_pkg::ID_W-1:0]   rid_q;
    logic                      rvalid_q;

    // the sram takes an active-high write enable, the bus carries wen low
    // for a write.
    // the row index is the word field above the bank select bits.
    tc_sram #(
      .NumWords  (l1_pkg::N_WORDS),
      .DataWidth (l1_pkg::DATA_W)
    ) i_bank (
      .clk_i   (clk_i),
      .rstn_i  (rstn_i),
      .req_i   (bank_req_i[i].req),
      .we_i    (~bank_req_i[i].wen),
      .addr_i  (bank_req_i[i].add[l1_pkg::ROW_LSB +: l1_pkg::ROW_W]),
      .wdata_i (bank_req_i[i].data),
      .be_i    (bank_req_i[i].be),
      .rdata_o (rdata)
    );

    // the id travels beside the read so that it comes out in the same
    // cycle as the data.
    // the valid flag follows every accepted request, reads and writes alike,
    // so each port sees exactly one response per request.
    always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
        rid_q    <= '0;
        rvalid_q <= 1'b0;
      end else begin
        rid_q    <= bank_req_i[i].id;
        rvalid_q <= bank_req_i[i].req;
      end
    end

    assign bank_rsp_o[i] = '{r_valid: rvalid_q, r_data: rdata, r_id: rid_q};

    // a response leaves the bank exactly one cycle after the request and
    // names the port that sent it.
    a_rsp_one_cycle: assert property (
      @(posedge clk_i) disable iff (!rstn_i)
      bank_req_i[i].req |=>
        (bank_rsp_o[i].r_valid && bank_rsp_o[i].r_id == $past(bank_req_i[i].id))
    );
  end

endmodule

//--- design/tcdm_req_xbar.sv
`timescale 1ns/1ps

module tcdm_req_xbar (
  input  logic                                   clk_i,
  input  logic                                   rstn_i,
  input  l1_pkg::mem_req_t [l1_pkg::N_PORTS-1:0] port_req_i,
  output logic [l1_pkg::N_PORTS-1:0]             gnt_o,
  output l1_pkg::mem_req_t [l1_pkg::N_BANK-1:0]  bank_req_o
);

  // winner vectors of all banks, one bit per port.
  logic [l1_pkg::N_BANK-1:0][l1_pkg::N_PORTS-1:0] bank_win;

  // cycles each port has been held off while requesting.
  logic [l1_pkg::N_PORTS-1:0][l1_pkg::ID_W:0] wait_q;

  for (genvar b = 0; b < l1_pkg::N_BANK; b++) begin : gen_bank
    logic [l1_pkg::N_PORTS-1:0] hit;
    logic [l1_pkg::N_PORTS-1:0] win;
    logic [l1_pkg::ID_W-1:0]    win_idx;
    logic [l1_pkg::ID_W-1:0]    rr_q;
    l1_pkg::mem_req_t           bank_req;

    // a port competes for this bank when its bank field selects it.
    always_comb begin
      for (int unsigned p = 0; p < l1_pkg::N_PORTS; p++) begin
        hit[p] = port_req_i[p].req &&
                 (port_req_i[p].add[l1_pkg::BANK_SEL_LSB +: l1_pkg::BANK_SEL_W] ==
                  l1_pkg::BANK_SEL_W'(b));
      end
    end

    // round-robin search.
    // rr_q is the port with the highest priority, the search walks up
    // from there and wraps around, and the first hit wins.
    always_comb begin : arbiter
      logic        found;
      int unsigned idx;
      found   = 1'b0;
      idx     = 0;
      win     = '0;
      win_idx = '0;
      for (int unsigned k = 0; k < l1_pkg::N_PORTS; k++) begin
        idx = (int'(rr_q) + k) % l1_pkg::N_PORTS;
        if (!found && hit[idx]) begin
          found        = 1'b1;
          win[idx]     = 1'b1;
          win_idx      = l1_pkg::ID_W'(idx);
        end
      end
    end

    // after a grant the port just above the winner takes top priority,
    // so the winner goes to the back of the line.
    always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
        rr_q <= '0;
      end else if (|win) begin
        rr_q <= l1_pkg::ID_W'((int'(win_idx) + 1) % l1_pkg::N_PORTS);
      end
    end

    // forward the winning request and stamp it with the port index.
    // without a winner the payload is don't care and req is low.
    always_comb begin
      bank_req     = port_req_i[win_idx];
      bank_req.req = |win;
      bank_req.id  = win_idx;
    end

    assign bank_req_o[b] = bank_req;
    assign bank_win[b]   = win;

    // a bank serves at most one port per cycle.
    a_one_winner: assert property (
      @(posedge clk_i) disable iff (!rstn_i)
      $onehot0(win)
    );
  end

  // a port targets a single bank, so at most one of these bits is set
  // per port and the OR is its grant.
  always_comb begin
    gnt_o = '0;
    for (int unsigned b = 0; b < l1_pkg::N_BANK; b++) begin
      gnt_o = gnt_o | bank_win[b];
    end
  end

  // a port that keeps losing must be served before every other port has
  // had one turn, which bounds its wait to N_PORTS-1 cycles.
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      wait_q <= '0;
    end else begin
      for (int unsigned p = 0; p < l1_pkg::N_PORTS; p++) begin
        if (port_req_i[p].req && !gnt_o[p]) begin
          wait_q[p] <= wait_q[p] + 1'b1;
        end else begin
          wait_q[p] <= '0;
        end
      end
    end
  end

  for (genvar p = 0; p < l1_pkg::N_PORTS; p++) begin : gen_port_chk
    // a grant only ever answers a live request.
    a_gnt_has_req: assert property (
      @(posedge clk_i) disable iff (!rstn_i)
      gnt_o[p] |-> port_req_i[p].req
    );

    // no port starves behind the others.
    a_no_starve: assert property (
      @(posedge clk_i) disable iff (!rstn_i)
      wait_q[p] < l1_pkg::N_PORTS
    );
  end

endmodule

//--- design/tcdm_rsp_xbar.sv
`timescale 1ns/1ps

module tcdm_rsp_xbar (
  input  l1_pkg::mem_rsp_t  [l1_pkg::N_BANK-1:0]  bank_rsp_i,
  output l1_pkg::port_rsp_t [l1_pkg::N_PORTS-1:0] port_rsp_o
);

  // hit[p][b] is set when bank b returns a response for port p.
  logic [l1_pkg::N_PORTS-1:0][l1_pkg::N_BANK-1:0] hit;

  // the registered id of each bank names the port the data belongs to.
  always_comb begin
    for (int unsigned p = 0; p < l1_pkg::N_PORTS; p++) begin
      for (int unsigned b = 0; b < l1_pkg::N_BANK; b++) begin
        hit[p][b] = bank_rsp_i[b].r_valid &&
                    (bank_rsp_i[b].r_id == l1_pkg::ID_W'(p));
      end
    end
  end

  // and-or mux per port.
  // at most one bank hits a port, so the or of the masked data is the
  // selected word.
  always_comb begin
    for (int unsigned p = 0; p < l1_pkg::N_PORTS; p++) begin
      port_rsp_o[p].r_valid = 1'b0;
      port_rsp_o[p].r_data  = '0;
      for (int unsigned b = 0; b < l1_pkg::N_BANK; b++) begin
        if (hit[p][b]) begin
          port_rsp_o[p].r_valid = 1'b1;
          port_rsp_o[p].r_data  = port_rsp_o[p].r_data | bank_rsp_i[b].r_data;
        end
      end
    end
  end

  // the request crossbar grants a port at most one bank per cycle, so
  // one cycle later at most one bank can answer that port.
  for (genvar p = 0; p < l1_pkg::N_PORTS; p++) begin : gen_port_chk
    always_comb begin
      a_one_rsp_per_port: assert final ($onehot0(hit[p]));
    end
  end

endmodule

//--- design/l1_spm_top.sv
`timescale 1ns/1ps

module l1_spm_top (
  input  logic                                    clk_i,
  input  logic                                    rstn_i,
  input  l1_pkg::mem_req_t  [l1_pkg::N_PORTS-1:0] port_req_i,
  output logic [l1_pkg::N_PORTS-1:0]              gnt_o,
  output l1_pkg::port_rsp_t [l1_pkg::N_PORTS-1:0] port_rsp_o
);

  // requests after arbitration, one per bank.
  l1_pkg::mem_req_t [l1_pkg::N_BANK-1:0] bank_req;

  // registered bank responses, tagged with the issuing port.
  l1_pkg::mem_rsp_t [l1_pkg::N_BANK-1:0] bank_rsp;

  // stage one decodes the bank of each port request and arbitrates.
  // grants return to the ports in the same cycle.
  tcdm_req_xbar i_req_xbar (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .port_req_i (port_req_i),
    .gnt_o      (gnt_o),
    .bank_req_o (bank_req)
  );

  // stage two holds the banks.
  // data, id and valid come out one cycle after the accepting edge.
  l1_mem_wrap i_mem_wrap (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .bank_req_i (bank_req),
    .bank_rsp_o (bank_rsp)
  );

  // stage three steers each response back to its port.
  tcdm_rsp_xbar i_rsp_xbar (
    .bank_rsp_i (bank_rsp),
    .port_rsp_o (port_rsp_o)
  );

endmodule

//--- bench/l1_spm_tb.sv
`timescale 1ns/1ps

module l1_spm_tb;

  localparam int unsigned SEED          = 32'h9b0a;
  localparam int unsigned N_TXN         = 3000;
  localparam int unsigned MAX_CYCLES    = 30000;
  localparam int unsigned CLK_PERIOD_NS = 4;
  // 32 words cover every bank four times, so conflicts and same-word hits are frequent.
  localparam int unsigned WINDOW_WORDS  = 32;

  logic                                    clk_i;
  logic                                    rstn_i;
  l1_pkg::mem_req_t  [l1_pkg::N_PORTS-1:0] port_req;
  logic [l1_pkg::N_PORTS-1:0]              gnt;
  l1_pkg::port_rsp_t [l1_pkg::N_PORTS-1:0] port_rsp;

  // reference copy of the memory, indexed by bank and row.
  logic [l1_pkg::DATA_W-1:0] shadow [l1_pkg::N_BANK][l1_pkg::N_WORDS];

  // one outstanding response per port, due at the next check.
  logic                      pend_valid [l1_pkg::N_PORTS];
  logic                      pend_read  [l1_pkg::N_PORTS];
  logic [l1_pkg::DATA_W-1:0] pend_data  [l1_pkg::N_PORTS];

  // set when the port was accepted at the last edge, so it is free again.
  logic        granted_q [l1_pkg::N_PORTS];
  int unsigned wait_cnt  [l1_pkg::N_PORTS];

  int unsigned issued;
  int unsigned accepted;
  int unsigned reads_checked;
  int unsigned cycles;

  l1_spm_top dut0 (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .port_req_i (port_req),
    .gnt_o      (gnt),
    .port_rsp_o (port_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;
    end
  end

  // bank field of a byte address.
  function automatic int unsigned bank_of(input logic [l1_pkg::ADDR_W-1:0] addr);
    return 32'(addr[l1_pkg::BANK_SEL_LSB +: l1_pkg::BANK_SEL_W]);
  endfunction

  // word index inside the bank, bits above it alias.
  function automatic int unsigned row_of(input logic [l1_pkg::ADDR_W-1:0] addr);
    return 32'(addr[l1_pkg::ROW_LSB +: l1_pkg::ROW_W]);
  endfunction

  // a write only touches the byte lanes whose enable is set.
  function automatic logic [l1_pkg::DATA_W-1:0] merge_bytes(
    input logic [l1_pkg::DATA_W-1:0] old,
    input logic [l1_pkg::DATA_W-1:0] data,
    input logic [l1_pkg::BE_W-1:0]   be
  );
    logic [l1_pkg::DATA_W-1:0] res;
    res = old;
    for (int unsigned i = 0; i < l1_pkg::BE_W; i++) begin
      if (be[i]) begin
        res[i*8 +: 8] = data[i*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic any_pending();
    logic res;
    res = 1'b0;
    for (int unsigned p = 0; p < l1_pkg::N_PORTS; p++) begin
      res = res | pend_valid[p];
    end
    return res;
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // with no request in flight every grant and every response stays low.
  task automatic check_idle_outputs();
    for (int unsigned p = 0; p < l1_pkg::N_PORTS; p++) begin
      check_value($sformatf("idle r_valid port %0d", p), 32'd0, 32'(port_rsp[p].r_valid));
    end
    check_value("idle gnt", 32'd0, 32'(gnt));
  endtask

  // responses belong to the requests accepted at the previous edge.
  // r_data of a write is undefined and is not compared.
  task automatic check_responses();
    for (int unsigned p = 0; p < l1_pkg::N_PORTS; p++) begin
      check_value($sformatf("r_valid port %0d", p), 32'(pend_valid[p]),
                  32'(port_rsp[p].r_valid));
      if (pend_valid[p] && pend_read[p]) begin
        check_value($sformatf("read data port %0d", p), pend_data[p], port_rsp[p].r_data);
        reads_checked++;
      end
      pend_valid[p] = 1'b0;
    end
  endtask

  // a port that still waits for its grant keeps every field stable.
  // a free port starts a new request three times out of four.
  task automatic drive_requests();
    logic [31:0]               r;
    logic [31:0]               word;
    logic [l1_pkg::ADDR_W-1:0] addr;
    for (int unsigned p = 0; p < l1_pkg::N_PORTS; p++) begin
      if (!port_req[p].req || granted_q[p]) begin
        r    = $urandom();
        word = $urandom_range(WINDOW_WORDS - 1, 0);
        addr = $urandom();
        addr[l1_pkg::ROW_LSB + l1_pkg::ROW_W - 1 : l1_pkg::BANK_SEL_LSB] =
          word[l1_pkg::ROW_W + l1_pkg::BANK_SEL_W - 1 : 0];
        if (issued < N_TXN && r[1:0] != 2'b00) begin
          port_req[p].req  = 1'b1;
          port_req[p].wen  = r[2];
          port_req[p].be   = r[6:3];
          port_req[p].id   = r[8:7];
          port_req[p].add  = addr;
          port_req[p].data = $urandom();
          issued++;
        end else begin
          port_req[p].req = 1'b0;
        end
      end
      granted_q[p] = 1'b0;
    end
  endtask

  // runs between the stimulus and the next rising edge, while grants are stable.
  task automatic sample_grants();
    int unsigned nreq [l1_pkg::N_BANK];
    int unsigned ngnt [l1_pkg::N_BANK];
    int unsigned b;
    for (int unsigned i = 0; i < l1_pkg::N_BANK; i++) begin
      nreq[i] = 0;
      ngnt[i] = 0;
    end
    for (int unsigned p = 0; p < l1_pkg::N_PORTS; p++) begin
      if (gnt[p]) begin
        check_value($sformatf("req behind gnt port %0d", p), 32'd1, 32'(port_req[p].req));
      end
      if (port_req[p].req) begin
        b = bank_of(port_req[p].add);
        nreq[b]++;
        if (gnt[p]) begin
          ngnt[b]++;
        end
      end
    end
    // a requested bank grants exactly one port, an idle bank none.
    for (int unsigned i = 0; i < l1_pkg::N_BANK; i++) begin
      check_value($sformatf("grants on bank %0d", i), (nreq[i] > 0) ? 32'd1 : 32'd0, ngnt[i]);
    end
    for (int unsigned p = 0; p < l1_pkg::N_PORTS; p++) begin
      if (port_req[p].req && nreq[bank_of(port_req[p].add)] == 1) begin
        check_value($sformatf("gnt without conflict port %0d", p), 32'd1, 32'(gnt[p]));
      end
      if (port_req[p].req && !gnt[p]) begin
        wait_cnt[p]++;
        if (wait_cnt[p] >= l1_pkg::N_PORTS) begin
          stop_on_error($sformatf("port %0d waited %0d cycles without a grant", p,
                                  wait_cnt[p]));
        end
      end else begin
        wait_cnt[p] = 0;
      end
    end
    // reads see the contents before any write accepted at the same edge.
    for (int unsigned p = 0; p < l1_pkg::N_PORTS; p++) begin
      granted_q[p] = port_req[p].req && gnt[p];
      if (granted_q[p]) begin
        pend_valid[p] = 1'b1;
        pend_read[p]  = port_req[p].wen;
        pend_data[p]  = shadow[bank_of(port_req[p].add)][row_of(port_req[p].add)];
        accepted++;
      end
    end
    for (int unsigned p = 0; p < l1_pkg::N_PORTS; p++) begin
      if (granted_q[p] && !port_req[p].wen) begin
        shadow[bank_of(port_req[p].add)][row_of(port_req[p].add)] =
          merge_bytes(shadow[bank_of(port_req[p].add)][row_of(port_req[p].add)],
                      port_req[p].data, port_req[p].be);
      end
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rstn_i        = 1'b0;
    port_req      = '0;
    issued        = 0;
    accepted      = 0;
    reads_checked = 0;
    cycles        = 0;
    for (int unsigned p = 0; p < l1_pkg::N_PORTS; p++) begin
      pend_valid[p] = 1'b0;
      pend_read[p]  = 1'b0;
      pend_data[p]  = '0;
      granted_q[p]  = 1'b0;
      wait_cnt[p]   = 0;
    end
    // the banks start out all zero.
    for (int unsigned b = 0; b < l1_pkg::N_BANK; b++) begin
      for (int unsigned w = 0; w < l1_pkg::N_WORDS; w++) begin
        shadow[b][w] = '0;
      end
    end

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rstn_i = 1'b1;

    repeat (3) begin
      @(negedge clk_i);
      check_idle_outputs();
    end

    // random traffic until every request has been accepted and answered.
    while ((accepted < N_TXN || any_pending()) && cycles < MAX_CYCLES) begin
      @(negedge clk_i);
      check_responses();
      drive_requests();
      #1;
      sample_grants();
      cycles++;
    end

    repeat (2) begin
      @(negedge clk_i);
      check_idle_outputs();
    end

    $display("%0d requests accepted, %0d read values compared in %0d cycles",
             accepted, reads_checked, cycles);
    if (accepted == N_TXN) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      stop_on_error($sformatf("only %0d of %0d requests accepted within %0d cycles",
                              accepted, N_TXN, MAX_CYCLES));
    end
  end

endmodule

//--- all.f
design/l1_pkg.sv
design/tc_sram.sv
design/l1_mem_wrap.sv
design/tcdm_req_xbar.sv
design/tcdm_rsp_xbar.sv
design/l1_spm_top.sv
bench/l1_spm_tb.sv

//--- run.sh
#!/bin/sh
# builds the scratchpad testbench with verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 --top-module l1_spm_tb -f all.f -o l1_spm_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/l1_spm_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if grep -q "^PASS: all tests$" "$LOG"; then
  echo "result: pass"
  exit 0
else
  echo "result: fail, see $LOG"
  exit 1
fi
